//--- build.f
+incdir+source
+incdir+tb
source/mips_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/alu.sv
source/pc_unit.sv
source/mips_core.sv
tb/tb_mips_core.sv

//--- tb/tb_mips_tests.svh
// directed tests for the mips core that each build a program, run it and check the results

    // ==============================
    // reset and alu
    // ==============================
    task automatic reset_behavior();
        word_t halt;
        start_program();
        // a store at the reset pc whose strobes stay off while in reset
        emit(i_instr(OP_SW, 5'd0, 5'd0, 16'd0));
        add_halt(halt);
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            check_pc("pc in reset", ir_addr, `MIPS_RESET_PC);
            check_strobe("cen in reset", cen, 1'b1);
            check_strobe("wen in reset", wen, 1'b1);
        end
        rst_n = 1'b0;
        #1;
        // the store at the reset pc is active once reset drops
        check_strobe("cen after reset", cen, 1'b0);
        check_strobe("wen after reset", wen, 1'b0);
        check_strobe("oen", oen, 1'b0);
        wait_halt(halt);
        check_word("store after reset", dmem[0], '0);
        report_test("reset");
    endtask

    task automatic alu_ops();
        word_t       halt;
        word_t       va;
        word_t       vb;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        logic        lt_ab;
        logic        lt_ba;
        start_program();
        imm_a = 16'(rand_bits(16));
        imm_b = 16'(rand_bits(16));
        va    = {{16{imm_a[15]}}, imm_a};
        vb    = {{16{imm_b[15]}}, imm_b};
        lt_ab = $signed(va) < $signed(vb);
        lt_ba = $signed(vb) < $signed(va);
        emit(i_instr(OP_ADDI, 5'd0, 5'd1, imm_a));
        emit(i_instr(OP_ADDI, 5'd0, 5'd2, imm_b));
        emit(r_instr(FN_ADD, 5'd1, 5'd2, 5'd3));
        emit(r_instr(FN_SUB, 5'd1, 5'd2, 5'd4));
        emit(r_instr(FN_AND, 5'd1, 5'd2, 5'd5));
        emit(r_instr(FN_OR, 5'd1, 5'd2, 5'd6));
        emit(r_instr(FN_SLT, 5'd1, 5'd2, 5'd7));
        emit(r_instr(FN_SLT, 5'd2, 5'd1, 5'd8));
        // r3 to r8 go to words 16 to 21
        for (int r = 3; r <= 8; r++) begin
            emit(i_instr(OP_SW, 5'd0, r[4:0], 16'((r + 13) * 4)));
        end
        add_halt(halt);
        run_program(halt);
        check_word("add", dmem[16], va + vb);
        check_word("sub", dmem[17], va - vb);
        check_word("and", dmem[18], va & vb);
        check_word("or", dmem[19], va | vb);
        check_word("slt a b", dmem[20], {31'd0, lt_ab});
        check_word("slt b a", dmem[21], {31'd0, lt_ba});
        report_test("alu");
    endtask

    // ==============================
    // memory and control flow
    // ==============================
    task automatic load_store();
        word_t halt;
        word_t x [4];
        start_program();
        for (int i = 0; i < 4; i++) begin
            x[i]         = rand_bits(32);
            dmem[32 + i] = x[i];
        end
        // base register points at word 32
        emit(i_instr(OP_ADDI, 5'd0, 5'd7, 16'd128));
        for (int i = 0; i < 4; i++) begin
            emit(i_instr(OP_LW, 5'd7, 5'(i + 1), 16'(i * 4)));
        end
        emit(r_instr(FN_ADD, 5'd1, 5'd2, 5'd5));
        emit(r_instr(FN_ADD, 5'd3, 5'd4, 5'd6));
        emit(i_instr(OP_SW, 5'd7, 5'd5, 16'd32));
        emit(i_instr(OP_SW, 5'd7, 5'd6, 16'd36));
        add_halt(halt);
        run_program(halt);
        check_word("sum word 40", dmem[40], x[0] + x[1]);
        check_word("sum word 41", dmem[41], x[2] + x[3]);
        check_word("word 39", dmem[39], fill_word(39));
        check_word("word 42", dmem[42], fill_word(42));
        check_word("source word 32", dmem[32], x[0]);
        report_test("load/store");
    endtask

    task automatic branches();
        word_t halt;
        start_program();
        emit(i_instr(OP_ADDI, 5'd0, 5'd1, 16'd5));
        emit(i_instr(OP_ADDI, 5'd0, 5'd2, 16'd5));
        emit(i_instr(OP_ADDI, 5'd0, 5'd3, 16'd7));
        emit(i_instr(OP_BEQ, 5'd1, 5'd3, 16'd3));
        emit(i_instr(OP_BEQ, 5'd1, 5'd2, 16'd4));
        emit(i_instr(OP_ADDI, 5'd0, 5'd4, 16'd1));
        emit(j_instr(OP_J, 26'd11));
        emit('0);
        emit('0);
        // backward branch into the skipped block
        emit(i_instr(OP_BEQ, 5'd0, 5'd0, 16'hfffb));
        emit('0);
        add_halt(halt);
        fetch_exp.delete();
        for (int p = 0; p <= 16; p += 4) begin
            fetch_exp.push_back(p);
        end
        fetch_exp.push_back(branch_dest(16, 16'd4));
        fetch_exp.push_back(branch_dest(36, 16'hfffb));
        fetch_exp.push_back(24);
        fetch_exp.push_back(jump_dest(24, 26'd11));
        run_fetch();
        report_test("branches");
    endtask

    task automatic jumps();
        word_t halt;
        start_program();
        emit(j_instr(OP_J, 26'd3));
        emit('0);
        emit('0);
        emit(j_instr(OP_JAL, 26'd6));
        emit(i_instr(OP_SW, 5'd0, 5'd31, 16'd200));
        emit(j_instr(OP_J, 26'd7));
        emit(r_instr(FN_JR, 5'd31, 5'd0, 5'd0));
        add_halt(halt);
        fetch_exp.delete();
        fetch_exp.push_back(0);
        fetch_exp.push_back(jump_dest(0, 26'd3));
        fetch_exp.push_back(jump_dest(12, 26'd6));
        // jr returns to the word after the jal
        fetch_exp.push_back(32'd12 + 32'd4);
        fetch_exp.push_back(20);
        fetch_exp.push_back(jump_dest(20, 26'd7));
        run_fetch();
        check_word("r31 after jal", dmem[50], 32'd12 + 32'd4);
        report_test("jumps");
    endtask

    task automatic zero_register();
        word_t       halt;
        logic [15:0] imm;
        start_program();
        imm      = 16'(rand_bits(16)) | 16'h0001;
        dmem[60] = rand_bits(32) | 32'h1;
        emit(i_instr(OP_ADDI, 5'd0, 5'd1, imm));
        emit(r_instr(FN_ADD, 5'd1, 5'd1, 5'd0));
        emit(i_instr(OP_LW, 5'd0, 5'd0, 16'd240));
        emit(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd3));
        emit(i_instr(OP_SW, 5'd0, 5'd0, 16'd244));
        emit(r_instr(FN_OR, 5'd0, 5'd1, 5'd2));
        emit(i_instr(OP_SW, 5'd0, 5'd2, 16'd248));
        add_halt(halt);
        run_program(halt);
        check_word("r0 stored", dmem[61], '0);
        check_word("r0 or r1", dmem[62], {{16{imm[15]}}, imm});
        report_test("register zero");
    endtask

//--- tb/tb_mips_core.sv
// testbench for the single-cycle mips core with memory models, program helpers and checks
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_core;

    import mips_pkg::*;

    localparam int imem_words = 64;
    localparam int prog_max   = 16;
    localparam int test_count = 6;
    // initial reset, then per test a short reset and the longest program, plus margin
    localparam int run_cycles = 16 + test_count * (2 + prog_max) + 100;

    logic                     clk;
    logic                     rst_n;
    word_t                    ir;
    word_t                    read_data_mem;
    word_t                    ir_addr;
    word_t                    rf_writedata;
    logic                     cen;
    logic                     wen;
    logic                     oen;
    logic [`MIPS_DMEM_AW-1:0] a;
    word_t                    mem_wdata;

    word_t       imem [imem_words];
    word_t       dmem [2**`MIPS_DMEM_AW];
    word_t       fetch_exp [$];
    int          prog_len;
    int          errors;
    int          test_errors;
    int          tests_failed;
    logic [15:0] lfsr_state;

    mips_core u_mips_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .ir            (ir),
        .read_data_mem (read_data_mem),
        .ir_addr       (ir_addr),
        .rf_writedata  (rf_writedata),
        .cen           (cen),
        .wen           (wen),
        .oen           (oen),
        .a             (a),
        .mem_wdata     (mem_wdata)
    );

    always #5 clk = ~clk;

    // ==============================
    // memory models
    // ==============================
    // both memories answer within the same cycle
    assign ir            = imem[ir_addr[7:2]];
    assign read_data_mem = dmem[a];

    always @(posedge clk) begin
        if (!cen && !wen) begin
            dmem[a] <= mem_wdata;
        end
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11 and one step per bit
    function automatic word_t rand_bits(int n);
        word_t w;
        logic  fb;
        w = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            w          = {w[`MIPS_XLEN-2:0], fb};
        end
        return w;
    endfunction

    function automatic word_t fill_word(int i);
        return 32'hc0de_0000 | i;
    endfunction

    // ==============================
    // instruction assembly
    // ==============================
    function automatic instr_t r_instr(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
        instr_t w;
        w              = '0;
        w.r_fmt.opcode = OP_RTYPE;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.rd     = rd;
        w.r_fmt.funct  = fn;
        return w;
    endfunction

    function automatic instr_t i_instr(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        instr_t w;
        w.i_fmt.opcode = op;
        w.i_fmt.rs     = rs;
        w.i_fmt.rt     = rt;
        w.i_fmt.imm16  = imm;
        return w;
    endfunction

    function automatic instr_t j_instr(opcode_t op, logic [25:0] target);
        instr_t w;
        w.j_fmt.opcode   = op;
        w.j_fmt.target26 = target;
        return w;
    endfunction

    // expected next fetch address of a taken beq and of j or jal
    function automatic word_t branch_dest(word_t pc, logic [15:0] off);
        return pc + 32'd4 + ({{16{off[15]}}, off} << 2);
    endfunction

    function automatic word_t jump_dest(word_t pc, logic [25:0] target);
        word_t pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], target, 2'b00};
    endfunction

    task automatic emit(instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // self jump that parks the core at the end of a program
    task automatic add_halt(output word_t halt_pc);
        halt_pc = prog_len * 4;
        emit(j_instr(OP_J, prog_len));
    endtask

    // ==============================
    // run control
    // ==============================
    task automatic start_program();
        rst_n       = 1'b1;
        prog_len    = 0;
        test_errors = 0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 2**`MIPS_DMEM_AW; i++) begin
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic release_core();
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        rst_n = 1'b0;
    endtask

    task automatic wait_halt(word_t halt_pc);
        while (ir_addr !== halt_pc) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_program(word_t halt_pc);
        release_core();
        wait_halt(halt_pc);
    endtask

    // one fetch address per cycle checked against fetch_exp
    task automatic run_fetch();
        instr_t cur;
        release_core();
        for (int k = 0; k < fetch_exp.size(); k++) begin
            if (k > 0) begin
                @(posedge clk);
                #1;
            end
            check_pc($sformatf("fetch step %0d", k), ir_addr, fetch_exp[k]);
            cur = ir;
            // jal puts its return address on the write path
            if (cur.j_fmt.opcode == OP_JAL) begin
                check_word("jal write data", rf_writedata, fetch_exp[k] + 32'd4);
            end
        end
    endtask

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_pc(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s fetch address %h expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_strobe(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s is %b expected %b", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(string name);
        if (test_errors == 0) begin
            $display("%-14s pass", name);
        end else begin
            $display("%-14s fail, %0d mismatches", name, test_errors);
            tests_failed++;
        end
    endtask

    `include "tb_mips_tests.svh"

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b1;
        lfsr_state   = 16'd35743;
        errors       = 0;
        tests_failed = 0;
        reset_behavior();
        alu_ops();
        load_store();
        branches();
        jumps();
        zero_register();
        $display("tests %0d, failed %0d, mismatches %0d", test_count, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(run_cycles * 10);
        $display("watchdog expired after %0d cycles, a program never reached its halt",
                 run_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- source/mips_core.sv
// single-cycle mips core: decode, register file, alu, pc and data memory port
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_pkg::word_t          ir,
    input  mips_pkg::word_t          read_data_mem,
    output mips_pkg::word_t          ir_addr,
    output mips_pkg::word_t          rf_writedata,
    output logic                     cen,
    output logic                     wen,
    output logic                     oen,
    output logic [`MIPS_DMEM_AW-1:0] a,
    output mips_pkg::word_t          mem_wdata
);

    import mips_pkg::*;

    instr_t    instr;

    logic      reg_write;
    logic      reg_dst;
    logic      alu_src;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    logic      jump;
    logic      link;
    logic      jump_reg;
    alu_op_t   alu_op;
    word_t     imm_ext;

    reg_addr_t rf_waddr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    word_t     pc;
    word_t     pc_plus4;

    assign instr = ir;

    instr_decoder u_instr_decoder (
        .instr      (instr),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .link       (link),
        .jump_reg   (jump_reg),
        .alu_op     (alu_op),
        .imm_ext    (imm_ext)
    );

    // ==============================
    // write-back path
    // ==============================
    // jal always targets r31
    assign rf_waddr     = link ? 5'd31 : (reg_dst ? instr.r_fmt.rd : instr.r_fmt.rt);
    assign rf_writedata = link ? pc_plus4 : (mem_to_reg ? read_data_mem : alu_result);

    register_file u_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (reg_write),
        .raddr1 (instr.r_fmt.rs),
        .raddr2 (instr.r_fmt.rt),
        .waddr  (rf_waddr),
        .wdata  (rf_writedata),
        .rdata1 (rs_data),
        .rdata2 (rt_data)
    );

    assign alu_b = alu_src ? imm_ext : rt_data;

    alu u_alu (
        .op     (alu_op),
        .a_in   (rs_data),
        .b_in   (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .branch   (branch),
        .zero     (alu_zero),
        .jump     (jump),
        .jump_reg (jump_reg),
        .target26 (instr.j_fmt.target26),
        .imm_ext  (imm_ext),
        .rs_data  (rs_data),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    assign ir_addr = pc;

    // ==============================
    // data memory port
    // ==============================
    // strobes are active low, instruction is idle while in reset
    assign cen       = ~((mem_read | mem_write) & ~rst_n);
    assign wen       = ~(mem_write & ~rst_n);
    assign oen       = 1'b0;
    // word address from the byte address
    assign a         = alu_result[`MIPS_DMEM_AW+1:2];
    assign mem_wdata = rt_data;

endmodule

//--- source/pc_unit.sv
// pc unit: program counter and next fetch address selection
`timescale 1ns/1ps
`include "mips_config.svh"

module pc_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch,
    input  logic            zero,
    input  logic            jump,
    input  logic            jump_reg,
    input  logic [25:0]     target26,
    input  mips_pkg::word_t imm_ext,
    input  mips_pkg::word_t rs_data,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t pc_plus4
);

    import mips_pkg::*;

    word_t branch_target;
    word_t jump_target;
    word_t pc_next;

    // ==============================
    // target addresses
    // ==============================
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + (imm_ext << 2);
    // region bits come from pc+4
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1 -: 4], target26, 2'b00};

    // register jump first, then jump, then taken branch
    always_comb begin
        if (jump_reg) begin
            pc_next = rs_data;
        end else if (jump) begin
            pc_next = jump_target;
        end else if (branch && zero) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- source/alu.sv
// alu: add, subtract, and, or, signed set-less-than, with zero flag
`timescale 1ns/1ps
`include "mips_config.svh"

module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a_in,
    input  mips_pkg::word_t   b_in,
    output mips_pkg::word_t   result,
    output logic              zero
);

    import mips_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a_in) < $signed(b_in);

    always_comb begin
        case (op)
            ALU_ADD: result = a_in + b_in;
            ALU_SUB: result = a_in - b_in;
            ALU_AND: result = a_in & b_in;
            ALU_OR:  result = a_in | b_in;
            // single result bit, rest cleared
            ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
            default: result = '0;
        endcase
    end

    // used by beq
    assign zero = (result == '0);

endmodule

//--- source/register_file.sv
// register file: 32 words, two combinational read ports, one clocked write port
`timescale 1ns/1ps
`include "mips_config.svh"

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t    wdata,
    output mips_pkg::word_t    rdata1,
    output mips_pkg::word_t    rdata2
);

    import mips_pkg::*;

    word_t regs [`MIPS_REG_COUNT];

    // write port, reset wins over a write
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // ==============================
    // read ports
    // ==============================
    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- source/instr_decoder.sv
// instruction decoder: control set, alu operation and sign-extended immediate
`timescale 1ns/1ps
`include "mips_config.svh"

module instr_decoder (
    input  mips_pkg::instr_t  instr,
    output logic              reg_write,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              mem_to_reg,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch,
    output logic              jump,
    output logic              link,
    output logic              jump_reg,
    output mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   imm_ext
);

    import mips_pkg::*;

    // sign extension of the 16-bit immediate
    assign imm_ext = {{(`MIPS_XLEN-16){instr.i_fmt.imm16[15]}}, instr.i_fmt.imm16};

    always_comb begin
        // defaults: no writes, no control transfer
        reg_write  = 1'b0;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        link       = 1'b0;
        jump_reg   = 1'b0;
        alu_op     = ALU_ADD;

        case (instr.r_fmt.opcode)
            OP_RTYPE: begin
                reg_dst = 1'b1;
                case (instr.r_fmt.funct)
                    FN_ADD: begin
                        reg_write = 1'b1;
                        alu_op    = ALU_ADD;
                    end
                    FN_SUB: begin
                        reg_write = 1'b1;
                        alu_op    = ALU_SUB;
                    end
                    FN_AND: begin
                        reg_write = 1'b1;
                        alu_op    = ALU_AND;
                    end
                    FN_OR: begin
                        reg_write = 1'b1;
                        alu_op    = ALU_OR;
                    end
                    FN_SLT: begin
                        reg_write = 1'b1;
                        alu_op    = ALU_SLT;
                    end
                    // jr only redirects the pc
                    FN_JR:   jump_reg = 1'b1;
                    default: reg_dst  = 1'b0;
                endcase
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                // compare by subtraction, zero flag decides
                branch = 1'b1;
                alu_op = ALU_SUB;
            end
            OP_J: jump = 1'b1;
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- source/mips_pkg.sv
// mips core shared types: opcodes, funct codes, alu operations, instruction formats
`include "mips_config.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_addr_t;

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // r-type function field
    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // ==============================
    // instruction formats
    // ==============================
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // one fetched word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

//--- source/mips_config.svh
// mips core configuration: word width, register count, data memory size, reset pc
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data and address word width
`define MIPS_XLEN 32

// general purpose registers
`define MIPS_REG_COUNT 32

// data memory word address width
`define MIPS_DMEM_AW 7

// fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif
